//--- build.f
+incdir+.
segre_pkg.sv
memory.sv
req_queue.sv
mem_arbiter.sv
load_align.sv
segre_mem_sys.sv
segre_mem_sys_props.sv
segre_mem_sys_tb.sv

//--- load_align.sv
`timescale 1ns/1ps

module load_align (
    input  segre_pkg::memop_data_type_e data_type_i,
    input  logic                        unsigned_i,
    input  segre_pkg::word_t            raw_i,
    output segre_pkg::word_t            data_o
);

    logic ext_bit;

    // the memory already returns the addressed byte in the low lane
    always_comb begin
        ext_bit = 1'b0;
        case (data_type_i)
            segre_pkg::BYTE: begin
                ext_bit = !unsigned_i && raw_i[7];
                data_o  = {{24{ext_bit}}, raw_i[7:0]};
            end
            segre_pkg::HALF: begin
                ext_bit = !unsigned_i && raw_i[15];
                data_o  = {{16{ext_bit}}, raw_i[15:0]};
            end
            segre_pkg::WORD: begin
                data_o = raw_i;
            end
            default: begin
                data_o = raw_i;
            end
        endcase
    end

endmodule

//--- mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        fetch_empty_i,
    input  segre_pkg::req_t             fetch_head_i,
    output logic                        fetch_pop_o,
    input  logic                        data_empty_i,
    input  segre_pkg::req_t             data_head_i,
    output logic                        data_pop_o,
    output logic                        mem_rd_o,
    output logic                        mem_wr_o,
    output segre_pkg::memop_data_type_e mem_type_o,
    output segre_pkg::addr_t            mem_addr_o,
    output segre_pkg::word_t            mem_wdata_o,
    output logic                        fetch_rvalid_o,
    output logic                        data_rvalid_o,
    output segre_pkg::memop_data_type_e data_type_o,
    output logic                        data_unsigned_o
);

    segre_pkg::port_e            grant;
    segre_pkg::port_e            last_grant;
    logic                        issue;
    segre_pkg::req_t             sel_head;

    logic                        s1_valid;
    segre_pkg::port_e            s1_port;
    segre_pkg::memop_data_type_e s1_type;
    logic                        s1_uns;
    logic                        s2_valid;
    segre_pkg::port_e            s2_port;
    segre_pkg::memop_data_type_e s2_type;
    logic                        s2_uns;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // round robin between the two queue heads
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        if (fetch_empty_i) begin
            grant = segre_pkg::PORT_DATA;
        end else if (data_empty_i) begin
            grant = segre_pkg::PORT_FETCH;
        end else if (last_grant == segre_pkg::PORT_FETCH) begin
            grant = segre_pkg::PORT_DATA;
        end else begin
            grant = segre_pkg::PORT_FETCH;
        end
    end

    assign issue       = !fetch_empty_i || !data_empty_i;
    assign fetch_pop_o = issue && (grant == segre_pkg::PORT_FETCH);
    assign data_pop_o  = issue && (grant == segre_pkg::PORT_DATA);
    assign sel_head    = (grant == segre_pkg::PORT_DATA) ? data_head_i : fetch_head_i;

    assign mem_wr_o    = issue && sel_head[segre_pkg::REQ_WE_BIT];
    assign mem_rd_o    = issue && !sel_head[segre_pkg::REQ_WE_BIT];
    assign mem_type_o  = segre_pkg::memop_data_type_e'(
                             sel_head[segre_pkg::REQ_TYPE_HI:segre_pkg::REQ_TYPE_LO]);
    assign mem_addr_o  = sel_head[segre_pkg::REQ_ADDR_HI:segre_pkg::REQ_ADDR_LO];
    assign mem_wdata_o = sel_head[segre_pkg::REQ_WDATA_HI:segre_pkg::REQ_WDATA_LO];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            last_grant <= segre_pkg::PORT_DATA;
        end else if (issue) begin
            last_grant <= grant;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // response tags, two stages to line up with the memory read
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= mem_rd_o;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk_i) begin
        s1_port <= grant;
        s1_type <= mem_type_o;
        s1_uns  <= sel_head[segre_pkg::REQ_UNS_BIT];
        s2_port <= s1_port;
        s2_type <= s1_type;
        s2_uns  <= s1_uns;
    end

    assign fetch_rvalid_o  = s2_valid && (s2_port == segre_pkg::PORT_FETCH);
    assign data_rvalid_o   = s2_valid && (s2_port == segre_pkg::PORT_DATA);
    assign data_type_o     = s2_type;
    assign data_unsigned_o = s2_uns;

endmodule

//--- memory.sv
`timescale 1ns/1ps

`include "segre_macros.svh"

module memory (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        rd_i,
    input  logic                        wr_i,
    input  segre_pkg::memop_data_type_e data_type_i,
    input  segre_pkg::addr_t            addr_i,
    input  segre_pkg::word_t            data_i,
    output segre_pkg::word_t            data_o
);

    localparam int IDX_W = $clog2(`SEGRE_MEM_BYTES);

    logic [7:0]       mem [`SEGRE_MEM_BYTES];
    logic [IDX_W-1:0] idx0;
    logic [IDX_W-1:0] idx1;
    logic [IDX_W-1:0] idx2;
    logic [IDX_W-1:0] idx3;
    segre_pkg::word_t rd_data;

    // byte lanes of one access, wrapping at the top of the array
    assign idx0 = addr_i[IDX_W-1:0];
    assign idx1 = idx0 + IDX_W'(1);
    assign idx2 = idx0 + IDX_W'(2);
    assign idx3 = idx0 + IDX_W'(3);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stores, little-endian, width taken from the operation type
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_i) begin
        if (wr_i) begin
            case (data_type_i)
                segre_pkg::BYTE: begin
                    mem[idx0] <= data_i[7:0];
                end
                segre_pkg::HALF: begin
                    mem[idx0] <= data_i[7:0];
                    mem[idx1] <= data_i[15:8];
                end
                segre_pkg::WORD: begin
                    mem[idx0] <= data_i[7:0];
                    mem[idx1] <= data_i[15:8];
                    mem[idx2] <= data_i[23:16];
                    mem[idx3] <= data_i[31:24];
                end
                default: ;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reads take two edges, first into rd_data and then onto data_o
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rd_data <= '0;
        end else if (rd_i) begin
            rd_data <= {mem[idx3], mem[idx2], mem[idx1], mem[idx0]};
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            data_o <= '0;
        end else begin
            data_o <= rd_data;
        end
    end

endmodule

//--- req_queue.sv
`timescale 1ns/1ps

`include "segre_macros.svh"

module req_queue (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             push_i,
    input  segre_pkg::req_t  push_data_i,
    input  logic             pop_i,
    output logic             empty_o,
    output segre_pkg::req_t  head_o,
    output logic             credit_o
);

    localparam int DEPTH = `SEGRE_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    segre_pkg::req_t             entries [DEPTH];
    logic [PTR_W-1:0]            wr_ptr;
    logic [PTR_W-1:0]            rd_ptr;
    logic [`SEGRE_CREDIT_W-1:0]  count;
    logic                        do_pop;

    assign empty_o = (count == '0);
    assign head_o  = entries[rd_ptr];
    assign do_pop  = pop_i && !empty_o;

    // a credit goes back to the requester for every entry that leaves
    assign credit_o = do_pop;

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            entries[wr_ptr] <= push_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // occupancy never exceeds DEPTH as long as the requester keeps to its credits
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            count <= '0;
        end else begin
            case ({push_i, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- segre_macros.svh
`ifndef SEGRE_MACROS_SVH
`define SEGRE_MACROS_SVH

// size of the byte array behind both ports
`define SEGRE_MEM_BYTES 65536

// entries per request queue, also the credits a requester starts with
`define SEGRE_QUEUE_DEPTH 4

// wide enough to count 0 up to SEGRE_QUEUE_DEPTH
`define SEGRE_CREDIT_W 3

`endif

//--- segre_mem_sys.sv
`timescale 1ns/1ps

module segre_mem_sys (
    input  logic                        clk_i,
    input  logic                        reset_i,
    // instruction fetch port
    input  logic                        fetch_valid_i,
    input  segre_pkg::addr_t            fetch_addr_i,
    output logic                        fetch_credit_o,
    output logic                        fetch_rvalid_o,
    output segre_pkg::word_t            fetch_rdata_o,
    // load and store port
    input  logic                        data_valid_i,
    input  logic                        data_we_i,
    input  segre_pkg::memop_data_type_e data_type_i,
    input  logic                        data_unsigned_i,
    input  segre_pkg::addr_t            data_addr_i,
    input  segre_pkg::word_t            data_wdata_i,
    output logic                        data_credit_o,
    output logic                        data_rvalid_o,
    output segre_pkg::word_t            data_rdata_o
);

    segre_pkg::req_t             fetch_entry;
    segre_pkg::req_t             data_entry;
    logic                        fetch_pop;
    logic                        fetch_empty;
    segre_pkg::req_t             fetch_head;
    logic                        data_pop;
    logic                        data_empty;
    segre_pkg::req_t             data_head;
    logic                        mem_rd;
    logic                        mem_wr;
    segre_pkg::memop_data_type_e mem_type;
    segre_pkg::addr_t            mem_addr;
    segre_pkg::word_t            mem_wdata;
    segre_pkg::word_t            mem_rdata;
    segre_pkg::memop_data_type_e align_type;
    logic                        align_unsigned;

    // fetches are always plain word reads
    assign fetch_entry = {1'b0, segre_pkg::WORD, 1'b0, fetch_addr_i, 32'h0};
    assign data_entry  = {data_we_i, data_type_i, data_unsigned_i, data_addr_i, data_wdata_i};

    req_queue u_fetch_queue (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .push_i      (fetch_valid_i),
        .push_data_i (fetch_entry),
        .pop_i       (fetch_pop),
        .empty_o     (fetch_empty),
        .head_o      (fetch_head),
        .credit_o    (fetch_credit_o)
    );

    req_queue u_data_queue (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .push_i      (data_valid_i),
        .push_data_i (data_entry),
        .pop_i       (data_pop),
        .empty_o     (data_empty),
        .head_o      (data_head),
        .credit_o    (data_credit_o)
    );

    mem_arbiter u_mem_arbiter (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .fetch_empty_i   (fetch_empty),
        .fetch_head_i    (fetch_head),
        .fetch_pop_o     (fetch_pop),
        .data_empty_i    (data_empty),
        .data_head_i     (data_head),
        .data_pop_o      (data_pop),
        .mem_rd_o        (mem_rd),
        .mem_wr_o        (mem_wr),
        .mem_type_o      (mem_type),
        .mem_addr_o      (mem_addr),
        .mem_wdata_o     (mem_wdata),
        .fetch_rvalid_o  (fetch_rvalid_o),
        .data_rvalid_o   (data_rvalid_o),
        .data_type_o     (align_type),
        .data_unsigned_o (align_unsigned)
    );

    memory u_memory (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .rd_i        (mem_rd),
        .wr_i        (mem_wr),
        .data_type_i (mem_type),
        .addr_i      (mem_addr),
        .data_i      (mem_wdata),
        .data_o      (mem_rdata)
    );

    // instruction words skip the load aligner
    assign fetch_rdata_o = mem_rdata;

    load_align u_load_align (
        .data_type_i (align_type),
        .unsigned_i  (align_unsigned),
        .raw_i       (mem_rdata),
        .data_o      (data_rdata_o)
    );

endmodule

//--- segre_mem_sys_props.sv
`timescale 1ns/1ps

`include "segre_macros.svh"

module segre_mem_sys_props (
    input logic                       clk_i,
    input logic                       reset_i,
    input logic                       fetch_push_i,
    input logic                       data_push_i,
    input logic [`SEGRE_CREDIT_W-1:0] fetch_count_i,
    input logic [`SEGRE_CREDIT_W-1:0] data_count_i,
    input logic                       fetch_credit_i,
    input logic                       data_credit_i,
    input logic                       mem_rd_i,
    input logic                       fetch_rvalid_i,
    input logic                       data_rvalid_i
);

    int fail_count = 0;

    // a requester that keeps to its credits never finds its queue full
    no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
        !(fetch_push_i && int'(fetch_count_i) == `SEGRE_QUEUE_DEPTH) &&
        !(data_push_i && int'(data_count_i) == `SEGRE_QUEUE_DEPTH))
    else begin
        $error("request pushed into a full queue");
        fail_count++;
    end

    // checked from the second reset edge on, once the registers have cleared
    reset_quiet: assert property (@(posedge clk_i)
        (reset_i && $past(reset_i)) |->
            !(fetch_credit_i || data_credit_i || fetch_rvalid_i || data_rvalid_i))
    else begin
        $error("credit or response active during reset");
        fail_count++;
    end

    read_response: assert property (@(posedge clk_i) disable iff (reset_i)
        mem_rd_i |-> ##2 (fetch_rvalid_i ^ data_rvalid_i))
    else begin
        $error("issued read not answered by exactly one response two cycles later");
        fail_count++;
    end

    single_response: assert property (@(posedge clk_i) disable iff (reset_i)
        !(fetch_rvalid_i && data_rvalid_i))
    else begin
        $error("fetch and data responses in the same cycle");
        fail_count++;
    end

endmodule

bind segre_mem_sys segre_mem_sys_props u_segre_mem_sys_props (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .fetch_push_i   (fetch_valid_i),
    .data_push_i    (data_valid_i),
    .fetch_count_i  (u_fetch_queue.count),
    .data_count_i   (u_data_queue.count),
    .fetch_credit_i (fetch_credit_o),
    .data_credit_i  (data_credit_o),
    .mem_rd_i       (mem_rd),
    .fetch_rvalid_i (fetch_rvalid_o),
    .data_rvalid_i  (data_rvalid_o)
);

//--- segre_mem_sys_tb.sv
`timescale 1ns/1ps

`include "segre_macros.svh"

module segre_mem_sys_tb;

    localparam int DEPTH          = `SEGRE_QUEUE_DEPTH;
    localparam int N_FILL         = 64;
    localparam int N_WORD         = 16;
    localparam int N_MERGE        = 16;
    localparam int N_NARROW       = 32;
    localparam int N_MIX          = 48;
    localparam int N_REQ          = 2 * N_FILL + 2 * N_WORD + 3 * N_MERGE + N_NARROW + 4 * N_MIX;
    localparam int TIMEOUT_CYCLES = N_REQ * 20 + 200;
    localparam segre_pkg::addr_t FETCH_BASE = 32'h0000_0100;
    localparam segre_pkg::addr_t DATA_BASE  = `SEGRE_MEM_BYTES / 2;

    logic                        clk;
    logic                        reset;
    logic                        fetch_valid;
    logic                        fetch_credit;
    logic                        fetch_rvalid;
    segre_pkg::addr_t            fetch_addr;
    segre_pkg::word_t            fetch_rdata;
    logic                        data_valid;
    logic                        data_we;
    logic                        data_unsigned;
    logic                        data_credit;
    logic                        data_rvalid;
    segre_pkg::memop_data_type_e data_type;
    segre_pkg::addr_t            data_addr;
    segre_pkg::word_t            data_wdata;
    segre_pkg::word_t            data_rdata;

    integer           seed;
    int               fetch_spent;
    int               fetch_returned;
    int               data_spent;
    int               data_returned;
    int               value_errors;
    int               other_errors;
    logic [7:0]       ref_mem [segre_pkg::addr_t];
    segre_pkg::word_t fetch_expected [$];
    segre_pkg::word_t data_expected [$];
    segre_pkg::addr_t word_addrs [N_WORD];

    segre_mem_sys u_segre_mem_sys (
        .clk_i           (clk),
        .reset_i         (reset),
        .fetch_valid_i   (fetch_valid),
        .fetch_addr_i    (fetch_addr),
        .fetch_credit_o  (fetch_credit),
        .fetch_rvalid_o  (fetch_rvalid),
        .fetch_rdata_o   (fetch_rdata),
        .data_valid_i    (data_valid),
        .data_we_i       (data_we),
        .data_type_i     (data_type),
        .data_unsigned_i (data_unsigned),
        .data_addr_i     (data_addr),
        .data_wdata_i    (data_wdata),
        .data_credit_o   (data_credit),
        .data_rvalid_o   (data_rvalid),
        .data_rdata_o    (data_rdata)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic int width_bytes(segre_pkg::memop_data_type_e kind);
        case (kind)
            segre_pkg::BYTE: return 1;
            segre_pkg::HALF: return 2;
            default:         return 4;
        endcase
    endfunction

    // little-endian bytes from the model, then extended unless the load is unsigned
    function automatic segre_pkg::word_t expected_read(segre_pkg::addr_t addr,
            segre_pkg::memop_data_type_e kind, logic uns);
        segre_pkg::word_t value;
        int               nbytes;
        value  = '0;
        nbytes = width_bytes(kind);
        for (int i = 0; i < nbytes; i++) begin
            value[8*i +: 8] = ref_mem[addr + 32'(i)];
        end
        if (!uns && nbytes < 4 && value[8*nbytes-1]) begin
            value = value | (32'hFFFF_FFFF << (8 * nbytes));
        end
        return value;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request drivers, each spends one credit per valid cycle
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic send_fetch(input segre_pkg::addr_t addr);
        while (fetch_spent - fetch_returned >= DEPTH) begin
            next_cycle();
        end
        fetch_valid = 1'b1;
        fetch_addr  = addr;
        fetch_spent++;
        fetch_expected.push_back(expected_read(addr, segre_pkg::WORD, 1'b0));
        next_cycle();
        fetch_valid = 1'b0;
    endtask

    task automatic send_data(input logic we, input segre_pkg::memop_data_type_e kind,
            input logic uns, input segre_pkg::addr_t addr, input segre_pkg::word_t wdata);
        while (data_spent - data_returned >= DEPTH) begin
            next_cycle();
        end
        data_valid    = 1'b1;
        data_we       = we;
        data_type     = kind;
        data_unsigned = uns;
        data_addr     = addr;
        data_wdata    = wdata;
        data_spent++;
        if (we) begin
            for (int i = 0; i < width_bytes(kind); i++) begin
                ref_mem[addr + 32'(i)] = wdata[8*i +: 8];
            end
        end else begin
            data_expected.push_back(expected_read(addr, kind, uns));
        end
        next_cycle();
        data_valid = 1'b0;
    endtask

    // random load or store of any width, kept inside the data region
    task automatic random_data_op();
        segre_pkg::memop_data_type_e kind;
        kind = segre_pkg::memop_data_type_e'(2'({$random(seed)} % 3));
        send_data(1'($random(seed)), kind, 1'($random(seed)),
                  DATA_BASE + 32'({$random(seed)} % 252), $random(seed));
    endtask

    task automatic check_word(input string port, input segre_pkg::word_t got,
            input segre_pkg::word_t want);
        assert (got === want) else begin
            value_errors++;
            $display("error at %0t: %s response %h, expected %h", $time, port, got, want);
        end
    endtask

    // credits are counted mid-cycle, where credit_o is settled
    initial begin
        forever begin
            @(negedge clk);
            if (!reset && fetch_credit) begin
                fetch_returned++;
            end
            if (!reset && data_credit) begin
                data_returned++;
            end
        end
    end

    initial begin
        forever begin
            @(negedge clk);
            if (!reset && fetch_rvalid) begin
                if (fetch_expected.size() == 0) begin
                    other_errors++;
                    $display("at %0t the fetch port answered with no fetch outstanding", $time);
                end else begin
                    check_word("fetch", fetch_rdata, fetch_expected.pop_front());
                end
            end
            if (!reset && data_rvalid) begin
                if (data_expected.size() == 0) begin
                    other_errors++;
                    $display("at %0t the data port answered with no load outstanding", $time);
                end else begin
                    check_word("data", data_rdata, data_expected.pop_front());
                end
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: the traffic did not drain within %0d cycles", TIMEOUT_CYCLES);
        $display("test failed");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        segre_pkg::addr_t addr;
        int               total_errors;
        seed           = 16549;
        fetch_spent    = 0;
        fetch_returned = 0;
        data_spent     = 0;
        data_returned  = 0;
        value_errors   = 0;
        other_errors   = 0;
        reset          = 1'b1;
        fetch_valid    = 1'b0;
        fetch_addr     = '0;
        data_valid     = 1'b0;
        data_we        = 1'b0;
        data_type      = segre_pkg::WORD;
        data_unsigned  = 1'b0;
        data_addr      = '0;
        data_wdata     = '0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        // instruction and data regions are filled through the data port
        for (int i = 0; i < N_FILL; i++) begin
            send_data(1'b1, segre_pkg::WORD, 1'b0, FETCH_BASE + 32'(4 * i), $random(seed));
            send_data(1'b1, segre_pkg::WORD, 1'b0, DATA_BASE + 32'(4 * i), $random(seed));
        end

        for (int i = 0; i < N_WORD; i++) begin
            word_addrs[i] = DATA_BASE + 32'(4 * ({$random(seed)} % 64));
            send_data(1'b1, segre_pkg::WORD, 1'b0, word_addrs[i], $random(seed));
        end
        for (int i = 0; i < N_WORD; i++) begin
            send_data(1'b0, segre_pkg::WORD, 1'b0, word_addrs[i], '0);
        end

        for (int i = 0; i < N_MERGE; i++) begin
            addr = DATA_BASE + 32'(4 * ({$random(seed)} % 64));
            send_data(1'b1, segre_pkg::BYTE, 1'b0, addr + 32'({$random(seed)} % 4),
                      $random(seed));
            send_data(1'b1, segre_pkg::HALF, 1'b0, addr + 32'(2 * ({$random(seed)} % 2)),
                      $random(seed));
            send_data(1'b0, segre_pkg::WORD, 1'b0, addr, '0);
        end

        // offsets walk through 0 to 3 so both aligned and unaligned loads occur
        for (int i = 0; i < N_NARROW; i++) begin
            addr = DATA_BASE + 32'(4 * ({$random(seed)} % 63)) + 32'((i / 2) % 4);
            send_data(1'b0, (i % 2 == 0) ? segre_pkg::BYTE : segre_pkg::HALF,
                      1'($random(seed)), addr, '0);
        end

        fork
            for (int i = 0; i < N_MIX; i++) begin
                send_fetch(FETCH_BASE + 32'(4 * i));
            end
            for (int i = 0; i < N_MIX; i++) begin
                random_data_op();
                repeat ({$random(seed)} % 3) begin
                    next_cycle();
                end
            end
        join

        // back-to-back requests on both ports run each requester out of credits
        fork
            for (int i = 0; i < N_MIX; i++) begin
                send_fetch(FETCH_BASE + 32'(4 * ((7 * i) % 64)));
            end
            for (int i = 0; i < N_MIX; i++) begin
                random_data_op();
            end
        join

        while (fetch_expected.size() != 0 || data_expected.size() != 0) begin
            next_cycle();
        end
        repeat (4 * DEPTH) begin
            next_cycle();
        end
        if (DEPTH - fetch_spent + fetch_returned != DEPTH) begin
            other_errors++;
            $display("fetch credits stuck at %0d after idle, should be back at %0d",
                     DEPTH - fetch_spent + fetch_returned, DEPTH);
        end
        if (DEPTH - data_spent + data_returned != DEPTH) begin
            other_errors++;
            $display("data credits stuck at %0d after idle, should be back at %0d",
                     DEPTH - data_spent + data_returned, DEPTH);
        end

        total_errors = value_errors + other_errors
                       + u_segre_mem_sys.u_segre_mem_sys_props.fail_count;
        $display("value errors: %0d, other errors: %0d, assertion failures: %0d",
                 value_errors, other_errors, u_segre_mem_sys.u_segre_mem_sys_props.fail_count);
        if (total_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- segre_pkg.sv
package segre_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [1:0]  byte_off_t;

    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } memop_data_type_e;

    typedef enum logic {
        PORT_FETCH = 1'b0,
        PORT_DATA  = 1'b1
    } port_e;

    // one queue entry, packed as {we, type, unsigned, addr, wdata}
    typedef logic [67:0] req_t;

    localparam int REQ_WE_BIT   = 67;
    localparam int REQ_TYPE_HI  = 66;
    localparam int REQ_TYPE_LO  = 65;
    localparam int REQ_UNS_BIT  = 64;
    localparam int REQ_ADDR_HI  = 63;
    localparam int REQ_ADDR_LO  = 32;
    localparam int REQ_WDATA_HI = 31;
    localparam int REQ_WDATA_LO = 0;

endpackage
